/* run_sim.sh */
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_dcache -f verilog.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vtb_dcache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
	exit 0
else
	echo "pass message not found in sim.log"
	exit 1
fi

/* sim/dcache_sva.sv */
// cache protocol assertions
`default_nettype none

module dcache_sva (
	input wire clk,
	input wire proc_reset,
	input wire proc_stall,
	input wire mem_read,
	input wire mem_write
);

	// one line transfer at a time
	a_single_strobe: assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_read && mem_write))
		else $error("mem_read and mem_write are high together");

	// memory traffic only happens on a miss
	a_strobe_stalls: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_read || mem_write) |-> proc_stall)
		else $error("memory strobe while the processor is not stalled");

	a_idle_after_reset: assert property (@(posedge clk)
		proc_reset |=> !proc_stall)
		else $error("proc_stall high in the cycle after reset");

endmodule

bind dcache_top dcache_sva i_sva (
	.clk        (clk),
	.proc_reset (proc_reset),
	.proc_stall (proc_stall),
	.mem_read   (mem_read),
	.mem_write  (mem_write)
);

`default_nettype wire

/* sim/tb_dcache.sv */
// data cache directed testbench
`default_nettype none

module tb_dcache;
	import dcache_pkg::*;

	localparam logic [31:0] seed            = 32'h91b80d31;
	localparam int          max_latency     = 6;
	localparam int          random_reqs     = 200;
	localparam int          num_requests    = 14 + random_reqs;
	localparam int          watchdog_cycles = num_requests * 40 + 10;

	logic        clk;
	logic        proc_reset;
	logic        proc_read;
	logic        proc_write;
	word_addr_t  proc_addr;
	word_t       proc_wdata;
	word_t       proc_rdata;
	logic        proc_stall;
	logic        mem_read;
	logic        mem_write;
	block_addr_t mem_addr;
	line_t       mem_wdata;
	line_t       mem_rdata;
	logic        mem_ready;

	line_t       mem_lines [block_addr_t]; // lines written back so far
	word_t       shadow [word_addr_t];     // every word the processor wrote
	logic [31:0] rng;
	int          error_count;
	int          rd_count;
	int          wr_count;
	block_addr_t last_rd_addr;
	block_addr_t last_wr_addr;
	line_t       last_wr_data;

	dcache_top i_dut (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// untouched memory reads as word address xor a fixed mark
	function automatic word_t pattern_word(input word_addr_t addr);
		return {2'b00, addr} ^ 32'h5a5a0000;
	endfunction

	function automatic line_t memory_line(input block_addr_t blk);
		line_t l;
		if (mem_lines.exists(blk)) begin
			return mem_lines[blk];
		end
		for (int i = 0; i < words_per_line; i++) begin
			l[i * 32 +: 32] = pattern_word({blk, 2'(i)});
		end
		return l;
	endfunction

	function automatic word_t expected_word(input word_addr_t addr);
		if (shadow.exists(addr)) begin
			return shadow[addr];
		end
		return pattern_word(addr);
	endfunction

	task automatic stop_on_error(input string msg);
		error_count++;
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	// one request, held until the stall drops
	task automatic access(input logic wr, input word_addr_t addr, input word_t wdata,
			output word_t rdata);
		@(posedge clk);
		proc_read  <= ~wr;
		proc_write <= wr;
		proc_addr  <= addr;
		proc_wdata <= wdata;
		do begin
			@(posedge clk);
		end while (proc_stall);
		rdata = proc_rdata;
		proc_read  <= 1'b0;
		proc_write <= 1'b0;
	endtask

	task automatic do_write(input word_addr_t addr, input word_t data);
		word_t ignored;
		access(1'b1, addr, data, ignored);
		shadow[addr] = data;
	endtask

	task automatic check_read(input word_addr_t addr);
		word_t got;
		word_t exp;
		access(1'b0, addr, '0, got);
		exp = expected_word(addr);
		assert (got == exp) else
			stop_on_error($sformatf("Mismatch at %0t: read of %h returned %h, expected %h",
				$time, addr, got, exp));
	endtask

	task automatic check_mem_counts(input int rd_exp, input int wr_exp);
		assert (rd_count == rd_exp && wr_count == wr_exp) else
			stop_on_error($sformatf("Mismatch at %0t: %0d line reads, %0d line writes, %s %0d and %0d",
				$time, rd_count, wr_count, "expected", rd_exp, wr_exp));
	endtask

	// ------------------------------------------------------------
	// slow line memory
	// ------------------------------------------------------------
	initial begin : memory_model
		block_addr_t addr;
		line_t       wdata;
		logic        is_wr;
		int unsigned delay;
		forever begin
			@(posedge clk);
			if (!proc_reset && (mem_read || mem_write)) begin
				assert (!(mem_read && mem_write) && proc_stall) else
					stop_on_error($sformatf("Bad memory request at %0t without a stall", $time));
				is_wr = mem_write;
				addr  = mem_addr;
				wdata = mem_wdata;
				delay = 1 + next_rand() % max_latency;
				repeat (delay - 1) begin
					@(posedge clk);
					assert ((is_wr ? mem_write : mem_read) && mem_addr == addr) else
						stop_on_error($sformatf("Memory request changed at %0t before mem_ready",
							$time));
				end
				if (is_wr) begin
					mem_lines[addr] = wdata;
					wr_count++;
					last_wr_addr = addr;
					last_wr_data = wdata;
				end else begin
					mem_rdata <= memory_line(addr);
					rd_count++;
					last_rd_addr = addr;
				end
				mem_ready <= 1'b1;
				@(posedge clk);
				mem_ready <= 1'b0; // one cycle pulse
			end
		end
	end

	initial begin : watchdog
		repeat (watchdog_cycles) @(posedge clk);
		stop_on_error($sformatf("Timeout at %0t: the cache did not finish its requests", $time));
	end

	// ------------------------------------------------------------
	// tests
	// ------------------------------------------------------------
	task automatic test_reset_idle();
		@(posedge clk);
		assert (proc_stall === 1'b0 && mem_read === 1'b0 && mem_write === 1'b0) else
			stop_on_error($sformatf("Mismatch at %0t: stall %b, mem_read %b, mem_write %b idle",
				$time, proc_stall, mem_read, mem_write));
	endtask

	task automatic test_read_miss();
		word_addr_t base;
		int         rd0;
		int         wr0;
		base = {26'h0012345, 2'd0, 2'd0};
		rd0  = rd_count;
		wr0  = wr_count;
		check_read({base[29:2], 2'd1});
		check_mem_counts(rd0 + 1, wr0);
		assert (last_rd_addr == base[29:2]) else
			stop_on_error($sformatf("Mismatch at %0t: line fill from %h, expected %h",
				$time, last_rd_addr, base[29:2]));
		for (int w = 0; w < words_per_line; w++) begin
			check_read({base[29:2], 2'(w)}); // whole line now hits
		end
		check_mem_counts(rd0 + 1, wr0);
	endtask

	task automatic test_write_hit();
		word_addr_t base;
		int         rd0;
		int         wr0;
		base = {26'h0012345, 2'd0, 2'd0};
		rd0  = rd_count;
		wr0  = wr_count;
		do_write({base[29:2], 2'd2}, 32'hcafe0002);
		for (int w = 0; w < words_per_line; w++) begin
			check_read({base[29:2], 2'(w)});
		end
		check_mem_counts(rd0, wr0);
	endtask

	// set 3 is untouched so far, so the third tag lands on the dirty way
	task automatic test_evict();
		word_addr_t a;
		word_addr_t b;
		word_addr_t c;
		word_t      data;
		int         rd0;
		int         wr0;
		a    = {26'h0000abc, 2'd3, 2'd1};
		b    = {26'h0000abd, 2'd3, 2'd0};
		c    = {26'h0000abe, 2'd3, 2'd2};
		data = 32'h12345678;
		rd0  = rd_count;
		wr0  = wr_count;
		do_write(a, data);
		check_read(b);
		check_read(c);
		check_mem_counts(rd0 + 3, wr0 + 1);
		assert (last_wr_addr == a[29:2] && last_wr_data[a[1:0] * 32 +: 32] == data) else
			stop_on_error($sformatf("Mismatch at %0t: write back to %h of %h",
				$time, last_wr_addr, last_wr_data));
		check_read(a);
	endtask

	task automatic test_random_mix();
		logic [31:0] r;
		word_addr_t  addr;
		for (int n = 0; n < random_reqs; n++) begin
			r    = next_rand();
			addr = {26'h0003000 + 26'(r[2:0]), r[4:3], r[6:5]}; // eight tags
			if (r[7]) begin
				do_write(addr, next_rand());
			end else begin
				check_read(addr);
			end
		end
	endtask

	initial begin
		proc_reset  = 1'b1;
		proc_read   = 1'b0;
		proc_write  = 1'b0;
		proc_addr   = '0;
		proc_wdata  = '0;
		mem_rdata   = '0;
		mem_ready   = 1'b0;
		rng         = seed;
		error_count = 0;
		rd_count    = 0;
		wr_count    = 0;
		repeat (4) @(posedge clk);
		proc_reset <= 1'b0;

		test_reset_idle();
		test_read_miss();
		test_write_hit();
		test_evict();
		test_random_mix();

		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src/dcache_ctrl.sv */
// data cache miss controller
`default_nettype none

module dcache_ctrl (
	input  wire  clk,
	input  wire  proc_reset,

	// processor request
	input  wire  proc_read,
	input  wire  proc_write,
	output logic proc_stall,

	// from the tag array
	input  wire  hit,
	input  wire  victim_dirty,

	// memory strobes
	output logic mem_read,
	output logic mem_write,
	input  wire  mem_ready,

	// array updates
	output logic fill_en,
	output logic write_hit_en,
	output logic wb_done
);
	import dcache_pkg::*;

	cache_state_t state;
	cache_state_t state_nxt;
	logic         req;
	logic         miss;

	assign req  = proc_read | proc_write;
	assign miss = req & ~hit;

	// ------------------------------------------------------------
	// state register
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	// ------------------------------------------------------------
	// next state
	// ------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				state_nxt = st_compare;
			end
			st_compare: begin
				if (miss) begin
					// dirty victim has to go out before the fill
					state_nxt = victim_dirty ? st_write_back : st_allocate;
				end
			end
			st_write_back: begin
				if (mem_ready) begin
					state_nxt = st_allocate;
				end
			end
			st_allocate: begin
				if (mem_ready) begin
					state_nxt = st_compare; // request hits next cycle
				end
			end
			default: begin
				state_nxt = st_idle;
			end
		endcase
	end

	// ------------------------------------------------------------
	// strobes
	// ------------------------------------------------------------
	always_comb begin
		proc_stall   = 1'b0;
		mem_read     = 1'b0;
		mem_write    = 1'b0;
		fill_en      = 1'b0;
		write_hit_en = 1'b0;
		wb_done      = 1'b0;
		case (state)
			st_idle: begin
				// arrays are not looked up yet, hold any early request
				proc_stall = req;
			end
			st_compare: begin
				proc_stall   = miss;
				write_hit_en = proc_write & hit;
			end
			st_write_back: begin
				proc_stall = 1'b1;
				mem_write  = ~mem_ready; // drops in the ready cycle
				wb_done    = mem_ready;
			end
			st_allocate: begin
				proc_stall = 1'b1;
				mem_read   = ~mem_ready;
				fill_en    = mem_ready;  // mem_rdata valid now
			end
			default: begin
				proc_stall = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

/* src/dcache_data_array.sv */
// data cache line storage
`default_nettype none

module dcache_data_array (
	input  wire                         clk,
	input  wire dcache_pkg::word_addr_t proc_addr,
	input  wire dcache_pkg::word_t      proc_wdata,
	input  wire dcache_pkg::line_t      mem_rdata,

	input  wire dcache_pkg::way_t       hit_way,
	input  wire dcache_pkg::way_t       victim_way,
	input  wire                         fill_en,
	input  wire                         write_hit_en,

	output dcache_pkg::word_t           proc_rdata,
	output dcache_pkg::line_t           victim_line
);
	import dcache_pkg::*;

	line_t     lines [num_ways][num_sets];

	set_idx_t  set;
	word_sel_t word_sel;
	line_t     hit_line;
	line_t     merged_line;

	assign set      = proc_addr[3:2];
	assign word_sel = proc_addr[1:0];

	assign hit_line    = lines[hit_way][set];
	assign victim_line = lines[victim_way][set]; // write-back data

	// addressed word of the hit way
	assign proc_rdata = hit_line[word_sel * $bits(word_t) +: $bits(word_t)];

	// ------------------------------------------------------------
	// word merge for write hits
	// ------------------------------------------------------------
	always_comb begin
		merged_line = hit_line;
		for (int i = 0; i < words_per_line; i++) begin
			if (word_sel == word_sel_t'(i)) begin
				merged_line[i * $bits(word_t) +: $bits(word_t)] = proc_wdata;
			end
		end
	end

	// ------------------------------------------------------------
	// line store
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (fill_en) begin
			lines[victim_way][set] <= mem_rdata;   // whole line from memory
		end else if (write_hit_en) begin
			lines[hit_way][set] <= merged_line;
		end
	end

endmodule

`default_nettype wire

/* src/dcache_pkg.sv */
// data cache shared definitions
`default_nettype none

package dcache_pkg;

	// ------------------------------------------------------------
	// cache geometry
	// ------------------------------------------------------------
	localparam int num_sets       = 4;
	localparam int num_ways       = 2;
	localparam int words_per_line = 4;

	// ------------------------------------------------------------
	// data and address types
	// ------------------------------------------------------------
	typedef logic [31:0]  word_t;       // processor data word
	typedef logic [127:0] line_t;       // one cache line, also the memory beat

	typedef logic [29:0]  word_addr_t;  // processor word address
	typedef logic [27:0]  block_addr_t; // memory line address

	// word address split
	// [29:4] tag, [3:2] set, [1:0] word in line
	typedef logic [25:0]  tag_t;
	typedef logic [1:0]   set_idx_t;
	typedef logic [1:0]   word_sel_t;

	typedef logic         way_t;

	// ------------------------------------------------------------
	// controller states
	// ------------------------------------------------------------
	typedef enum logic [1:0] {
		st_compare    = 2'b00,
		st_write_back = 2'b01,
		st_allocate   = 2'b10,
		st_idle       = 2'b11   // only seen right after reset
	} cache_state_t;

endpackage

`default_nettype wire

/* src/dcache_tag_array.sv */
// data cache tag and state bits
`default_nettype none

module dcache_tag_array (
	input  wire                      clk,
	input  wire                      proc_reset,
	input  wire dcache_pkg::word_addr_t proc_addr,

	// updates from the controller
	input  wire                      fill_en,
	input  wire                      write_hit_en,
	input  wire                      wb_done,
	input  wire                      mem_write,

	output logic                     hit,
	output dcache_pkg::way_t         hit_way,
	output dcache_pkg::way_t         victim_way,
	output logic                     victim_dirty,
	output dcache_pkg::block_addr_t  mem_addr
);
	import dcache_pkg::*;

	logic     valid      [num_ways][num_sets];
	logic     dirty      [num_ways][num_sets];
	tag_t     tags       [num_ways][num_sets];
	way_t     victim_ptr [num_sets];   // next way to replace

	tag_t     tag;
	set_idx_t set;

	assign tag = proc_addr[29:4];
	assign set = proc_addr[3:2];

	// ------------------------------------------------------------
	// lookup, both ways at once
	// ------------------------------------------------------------
	always_comb begin
		hit     = 1'b0;
		hit_way = '0;
		for (int w = 0; w < num_ways; w++) begin
			if (valid[w][set] && (tags[w][set] == tag)) begin
				hit     = 1'b1;
				hit_way = way_t'(w);
			end
		end
	end

	assign victim_way   = victim_ptr[set];
	assign victim_dirty = valid[victim_way][set] & dirty[victim_way][set];

	// victim line address while writing back, else the requested line
	assign mem_addr = mem_write ? {tags[victim_way][set], set} : proc_addr[29:2];

	// ------------------------------------------------------------
	// valid, dirty and replacement bits
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int s = 0; s < num_sets; s++) begin
				victim_ptr[s] <= '0;
				for (int w = 0; w < num_ways; w++) begin
					valid[w][s] <= 1'b0;
					dirty[w][s] <= 1'b0;
				end
			end
		end else begin
			if (write_hit_en) begin
				dirty[hit_way][set] <= 1'b1;
			end
			if (wb_done) begin
				dirty[victim_way][set] <= 1'b0; // line now matches memory
			end
			if (fill_en) begin
				valid[victim_way][set] <= 1'b1;
				dirty[victim_way][set] <= 1'b0;
				victim_ptr[set]        <= ~victim_ptr[set]; // alternate ways
			end
		end
	end

	// tag store
	always_ff @(posedge clk) begin
		if (fill_en) begin
			tags[victim_way][set] <= tag;
		end
	end

endmodule

`default_nettype wire

/* src/dcache_top.sv */
// two-way write-back data cache
`default_nettype none

module dcache_top (
	input  wire                          clk,
	input  wire                          proc_reset,

	// processor port
	input  wire                          proc_read,
	input  wire                          proc_write,
	input  wire dcache_pkg::word_addr_t  proc_addr,
	input  wire dcache_pkg::word_t       proc_wdata,
	output dcache_pkg::word_t            proc_rdata,
	output logic                         proc_stall,

	// memory port, one line per transfer
	output logic                         mem_read,
	output logic                         mem_write,
	output dcache_pkg::block_addr_t      mem_addr,
	output dcache_pkg::line_t            mem_wdata,
	input  wire dcache_pkg::line_t       mem_rdata,
	input  wire                          mem_ready
);
	import dcache_pkg::*;

	// ------------------------------------------------------------
	// internal wires
	// ------------------------------------------------------------
	logic hit;
	logic victim_dirty;
	logic fill_en;
	logic write_hit_en;
	logic wb_done;
	way_t hit_way;
	way_t victim_way;

	dcache_ctrl i_ctrl (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_read    (proc_read),
		.proc_write   (proc_write),
		.proc_stall   (proc_stall),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_ready    (mem_ready),
		.fill_en      (fill_en),
		.write_hit_en (write_hit_en),
		.wb_done      (wb_done)
	);

	dcache_tag_array i_tags (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_addr    (proc_addr),
		.fill_en      (fill_en),
		.write_hit_en (write_hit_en),
		.wb_done      (wb_done),
		.mem_write    (mem_write),
		.hit          (hit),
		.hit_way      (hit_way),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.mem_addr     (mem_addr)
	);

	dcache_data_array i_data (
		.clk          (clk),
		.proc_addr    (proc_addr),
		.proc_wdata   (proc_wdata),
		.mem_rdata    (mem_rdata),
		.hit_way      (hit_way),
		.victim_way   (victim_way),
		.fill_en      (fill_en),
		.write_hit_en (write_hit_en),
		.proc_rdata   (proc_rdata),
		.victim_line  (mem_wdata)     // victim goes straight to memory
	);

endmodule

`default_nettype wire

/* verilog.f */
src/dcache_pkg.sv
src/dcache_ctrl.sv
src/dcache_tag_array.sv
src/dcache_data_array.sv
src/dcache_top.sv
sim/dcache_sva.sv
sim/tb_dcache.sv
